// ==== src/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// First instruction fetched after reset
`define CORE_RESET_VECTOR 32'hFF100000

// Data and address width
`define CORE_XLEN 32

// Integer register count, x0 included
`define CORE_NUM_REGS 32

`endif

// ==== src/rv_isa_pkg.sv ====
`include "core_settings.svh"

package rv_isa_pkg;

    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // funct3 for OP and OP_IMM
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,  // SRL or SRA by alt bit
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_op_e;

    // Load/store access size
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101
    } mem_size_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [2:0]             funct3;
        logic                   alt;     // funct7 bit 5
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic [`CORE_XLEN-1:0]  imm;     // Sign extended, format already chosen
    } decoded_instr_t;

endpackage

// ==== src/core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

    // Control FSM states
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC   = 2'd1,
        MEM_RD = 2'd2,
        MEM_WR = 2'd3
    } ctrl_state_e;

    // Outgoing bus request, all fields registered
    typedef struct packed {
        logic [`CORE_XLEN-1:0]     addr;
        logic [`CORE_XLEN-1:0]     wrdata;
        logic [`CORE_XLEN/8-1:0]   bytesel;
        logic                      wren;
        logic                      strobe;
    } bus_req_t;

endpackage

// ==== src/instr_decoder.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module instr_decoder (
    input  logic [`CORE_XLEN-1:0]      instr,
    output rv_isa_pkg::decoded_instr_t dec
);
    import rv_isa_pkg::*;

    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_j;
    opcode_e               opcode;

    assign opcode = opcode_e'(instr[6:0]);

    ////////////////////////////////////////////////////////////
    // Immediates for each format
    ////////////////////////////////////////////////////////////
    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = instr[14:12];
        dec.alt    = instr[30];
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];

        // Pick the immediate by format
        case (opcode)
            OPC_LUI,
            OPC_AUIPC:  dec.imm = imm_u;
            OPC_JAL:    dec.imm = imm_j;
            OPC_BRANCH: dec.imm = imm_b;
            OPC_STORE:  dec.imm = imm_s;
            default:    dec.imm = imm_i;  // JALR, loads, OP_IMM and the rest
        endcase
    end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module register_file (
    input  logic                               clk,
    input  logic [$clog2(`CORE_NUM_REGS)-1:0]  rs1_idx,
    input  logic [$clog2(`CORE_NUM_REGS)-1:0]  rs2_idx,
    input  logic [$clog2(`CORE_NUM_REGS)-1:0]  rd_idx,
    input  logic                               rd_wr,
    input  logic [`CORE_XLEN-1:0]              rd_data,
    output logic [`CORE_XLEN-1:0]              rs1_data,
    output logic [`CORE_XLEN-1:0]              rs2_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rd_wr && rd_idx != '0)  // x0 is never written
            regs[rd_idx] <= rd_data;
    end

    // Entry 0 is never written, so x0 reads back as a constant
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    x0_reads_zero: assert property (@(posedge clk)
        (rs1_idx == '0 |-> rs1_data == '0) and (rs2_idx == '0 |-> rs2_data == '0));

endmodule

// ==== src/alu.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module alu (
    input  rv_isa_pkg::decoded_instr_t dec,
    input  logic [`CORE_XLEN-1:0]      rs1_data,
    input  logic [`CORE_XLEN-1:0]      rs2_data,
    output logic [`CORE_XLEN-1:0]      result,
    output logic                       take_branch
);
    import rv_isa_pkg::*;

    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic [`CORE_XLEN:0]   diff;     // Extra bit is the unsigned borrow
    logic                  is_eq;
    logic                  is_lt;
    logic                  is_ltu;
    logic                  shr_fill;
    logic [`CORE_XLEN-1:0] shl1, shl2, shl4, shl8, shl16;
    logic [`CORE_XLEN-1:0] shr1, shr2, shr4, shr8, shr16;

    // Register operand for OP and BRANCH, immediate otherwise
    assign op_b  = (dec.opcode == OPC_OP || dec.opcode == OPC_BRANCH) ? rs2_data : dec.imm;
    assign shamt = (dec.opcode == OPC_OP_IMM) ? dec.imm[4:0] : rs2_data[4:0];

    assign diff   = {1'b0, rs1_data} - {1'b0, op_b};
    assign is_eq  = (diff[`CORE_XLEN-1:0] == '0);
    assign is_ltu = diff[`CORE_XLEN];
    assign is_lt  = (rs1_data[`CORE_XLEN-1] != op_b[`CORE_XLEN-1]) ?
                    rs1_data[`CORE_XLEN-1] : diff[`CORE_XLEN];

    ////////////////////////////////////////////////////////////
    // Barrel shifters, one stage per shamt bit
    ////////////////////////////////////////////////////////////
    assign shl1  = shamt[0] ? {rs1_data[30:0], 1'b0} : rs1_data;
    assign shl2  = shamt[1] ? {shl1[29:0], 2'b0}     : shl1;
    assign shl4  = shamt[2] ? {shl2[27:0], 4'b0}     : shl2;
    assign shl8  = shamt[3] ? {shl4[23:0], 8'b0}     : shl4;
    assign shl16 = shamt[4] ? {shl8[15:0], 16'b0}    : shl8;

    assign shr_fill = dec.alt & rs1_data[`CORE_XLEN-1];  // SRA
    assign shr1  = shamt[0] ? {shr_fill, rs1_data[31:1]}    : rs1_data;
    assign shr2  = shamt[1] ? {{2{shr_fill}}, shr1[31:2]}   : shr1;
    assign shr4  = shamt[2] ? {{4{shr_fill}}, shr2[31:4]}   : shr2;
    assign shr8  = shamt[3] ? {{8{shr_fill}}, shr4[31:8]}   : shr4;
    assign shr16 = shamt[4] ? {{16{shr_fill}}, shr8[31:16]} : shr8;

    always_comb begin
        case (alu_op_e'(dec.funct3))
            ALU_ADD:  result = (dec.opcode == OPC_OP && dec.alt) ?
                               diff[`CORE_XLEN-1:0] : rs1_data + op_b;
            ALU_SLL:  result = shl16;
            ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, is_lt};
            ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, is_ltu};
            ALU_XOR:  result = rs1_data ^ op_b;
            ALU_SR:   result = shr16;
            ALU_OR:   result = rs1_data | op_b;
            default:  result = rs1_data & op_b;  // AND
        endcase
    end

    // Branch decision
    always_comb begin
        case (branch_op_e'(dec.funct3))
            BR_BEQ:  take_branch = is_eq;
            BR_BNE:  take_branch = !is_eq;
            BR_BLT:  take_branch = is_lt;
            BR_BGE:  take_branch = !is_lt;
            BR_BLTU: take_branch = is_ltu;
            BR_BGEU: take_branch = !is_ltu;
            default: take_branch = 1'b0;
        endcase
        if (dec.opcode != OPC_BRANCH)
            take_branch = 1'b0;
    end

endmodule

// ==== src/load_store_unit.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module load_store_unit (
    input  rv_isa_pkg::decoded_instr_t dec,
    input  logic [`CORE_XLEN-1:0]      rs1_data,
    input  logic [`CORE_XLEN-1:0]      rs2_data,
    input  logic [`CORE_XLEN-1:0]      rddata,
    output logic [`CORE_XLEN-1:0]      addr,
    output logic [`CORE_XLEN-1:0]      wrdata,
    output logic [3:0]                 bytesel,
    output logic [`CORE_XLEN-1:0]      load_data
);
    import rv_isa_pkg::*;

    logic [`CORE_XLEN-1:0] lane;  // Read data moved down to byte 0
    mem_size_e             size;
    logic                  is_store;

    assign size     = mem_size_e'(dec.funct3);
    assign is_store = (dec.opcode == OPC_STORE);

    // Decoder already picked the I or S immediate
    assign addr = rs1_data + dec.imm;

    ////////////////////////////////////////////////////////////
    // Store side
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   wrdata = {4{rs2_data[7:0]}};
            2'b01:   wrdata = {2{rs2_data[15:0]}};
            default: wrdata = rs2_data;
        endcase

        if (!is_store)
            bytesel = 4'b1111;  // Loads read the whole word
        else if (dec.funct3[1:0] == 2'b00)
            bytesel = 4'b0001 << addr[1:0];
        else if (dec.funct3[1:0] == 2'b01)
            bytesel = addr[1] ? 4'b1100 : 4'b0011;
        else
            bytesel = 4'b1111;
    end

    ////////////////////////////////////////////////////////////
    // Load side
    ////////////////////////////////////////////////////////////
    assign lane = rddata >> {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            SZ_B:    load_data = {{24{lane[7]}}, lane[7:0]};
            SZ_H:    load_data = {{16{lane[15]}}, lane[15:0]};
            SZ_BU:   load_data = {24'b0, lane[7:0]};
            SZ_HU:   load_data = {16'b0, lane[15:0]};
            default: load_data = rddata;  // LW
        endcase
    end

    // Halfword stores only ever touch one half of the word
    half_lanes: assert final (!(is_store && size == SZ_H) ||
                              bytesel == 4'b0011 || bytesel == 4'b1100);

endmodule

// ==== src/cpu_control.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module cpu_control (
    input  logic                       clk,
    input  logic                       reset,
    input  rv_isa_pkg::decoded_instr_t dec,
    input  logic [`CORE_XLEN-1:0]      alu_result,
    input  logic                       take_branch,
    input  logic [`CORE_XLEN-1:0]      lsu_addr,
    input  logic [`CORE_XLEN-1:0]      lsu_wrdata,
    input  logic [3:0]                 lsu_bytesel,
    input  logic [`CORE_XLEN-1:0]      load_data,
    input  logic                       bus_wait,
    input  logic [`CORE_XLEN-1:0]      bus_rddata,
    output logic [`CORE_XLEN-1:0]      instr,
    output logic                       rd_wr,
    output logic [`CORE_XLEN-1:0]      rd_data,
    output core_pkg::bus_req_t         bus_req
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    ctrl_state_e           state, state_next;
    logic [`CORE_XLEN-1:0] pc, pc_next;
    logic [`CORE_XLEN-1:0] instr_next;
    bus_req_t              req_next;
    logic [`CORE_XLEN-1:0] pc_plus4;
    logic [`CORE_XLEN-1:0] pc_plus_imm;
    logic [`CORE_XLEN-1:0] target;
    logic                  is_mem;
    logic                  writes_rd;

    // Word-aligned fetch request, write data left as it was
    function automatic bus_req_t fetch_req(input logic [`CORE_XLEN-1:0] fetch_addr,
                                           input bus_req_t cur);
        bus_req_t r;
        r         = cur;
        r.addr    = {fetch_addr[`CORE_XLEN-1:2], 2'b00};
        r.bytesel = 4'b1111;
        r.wren    = 1'b0;
        r.strobe  = 1'b1;
        return r;
    endfunction

    assign pc_plus4    = pc + `CORE_XLEN'd4;
    assign pc_plus_imm = pc + dec.imm;  // J, B or U immediate by opcode
    assign is_mem      = (dec.opcode == OPC_LOAD || dec.opcode == OPC_STORE);
    assign writes_rd   = dec.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                            OPC_OP, OPC_OP_IMM};

    always_comb begin
        if (dec.opcode == OPC_JALR)
            target = alu_result;                   // rs1 + imm from the adder
        else if (dec.opcode == OPC_JAL || take_branch)
            target = pc_plus_imm;
        else
            target = pc_plus4;                     // Also FENCE, SYSTEM, unknown
    end

    ////////////////////////////////////////////////////////////
    // Write-back select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (dec.opcode)
            OPC_LUI:            rd_data = dec.imm;
            OPC_AUIPC:          rd_data = pc_plus_imm;
            OPC_JAL, OPC_JALR:  rd_data = pc_plus4;  // Link address
            OPC_LOAD:           rd_data = load_data;
            default:            rd_data = alu_result;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        pc_next    = pc;
        instr_next = instr;
        req_next   = bus_req;
        rd_wr      = 1'b0;

        case (state)
            FETCH: begin
                if (!bus_wait) begin
                    instr_next      = bus_rddata;
                    req_next.strobe = 1'b0;  // Bus idle during EXEC
                    state_next      = EXEC;
                end
            end
            EXEC: begin
                if (is_mem) begin
                    req_next.addr    = lsu_addr;
                    req_next.wrdata  = lsu_wrdata;
                    req_next.bytesel = lsu_bytesel;
                    req_next.wren    = (dec.opcode == OPC_STORE);
                    req_next.strobe  = 1'b1;
                    state_next       = (dec.opcode == OPC_STORE) ? MEM_WR : MEM_RD;
                end else begin
                    rd_wr      = writes_rd;
                    pc_next    = {target[`CORE_XLEN-1:2], 2'b00};
                    req_next   = fetch_req(target, bus_req);
                    state_next = FETCH;
                end
            end
            default: begin  // MEM_RD, MEM_WR
                if (!bus_wait) begin
                    rd_wr      = (state == MEM_RD);  // Load data valid this cycle
                    pc_next    = pc_plus4;
                    req_next   = fetch_req(pc_plus4, bus_req);
                    state_next = FETCH;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= FETCH;
            pc              <= `CORE_RESET_VECTOR;
            instr           <= '0;
            bus_req.addr    <= `CORE_RESET_VECTOR;
            bus_req.wrdata  <= '0;
            bus_req.bytesel <= 4'b1111;
            bus_req.wren    <= 1'b0;
            bus_req.strobe  <= 1'b1;       // First fetch opens straight out of reset
        end else begin
            state   <= state_next;
            pc      <= pc_next;
            instr   <= instr_next;
            bus_req <= req_next;
        end
    end

    // Back-pressure holds the request as it is
    req_hold: assert property (@(posedge clk) disable iff (reset)
        bus_req.strobe && bus_wait |=> $stable(bus_req));

    wren_in_store: assert property (@(posedge clk) disable iff (reset)
        bus_req.wren |-> state == MEM_WR);

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module cpu_top (
    input  logic                  clk,
    input  logic                  reset,
    output core_pkg::bus_req_t    bus_req,
    input  logic                  bus_wait,
    input  logic [`CORE_XLEN-1:0] bus_rddata
);
    import rv_isa_pkg::*;

    decoded_instr_t        dec;
    logic [`CORE_XLEN-1:0] instr;
    logic [`CORE_XLEN-1:0] rs1_data, rs2_data;
    logic [`CORE_XLEN-1:0] rd_data;
    logic                  rd_wr;
    logic [`CORE_XLEN-1:0] alu_result;
    logic                  take_branch;
    logic [`CORE_XLEN-1:0] lsu_addr, lsu_wrdata, load_data;
    logic [3:0]            lsu_bytesel;

    ////////////////////////////////////////////////////////////
    // Datapath units
    ////////////////////////////////////////////////////////////
    instr_decoder u_decoder (.instr(instr), .dec(dec));

    register_file u_regs (
        .clk(clk), .rs1_idx(dec.rs1), .rs2_idx(dec.rs2), .rd_idx(dec.rd),
        .rd_wr(rd_wr), .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu u_alu (
        .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .result(alu_result), .take_branch(take_branch)
    );

    load_store_unit u_lsu (
        .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data), .rddata(bus_rddata),
        .addr(lsu_addr), .wrdata(lsu_wrdata), .bytesel(lsu_bytesel), .load_data(load_data)
    );

    // Sequencing and the bus registers
    cpu_control u_control (
        .clk(clk), .reset(reset), .dec(dec),
        .alu_result(alu_result), .take_branch(take_branch),
        .lsu_addr(lsu_addr), .lsu_wrdata(lsu_wrdata), .lsu_bytesel(lsu_bytesel),
        .load_data(load_data), .bus_wait(bus_wait), .bus_rddata(bus_rddata),
        .instr(instr), .rd_wr(rd_wr), .rd_data(rd_data), .bus_req(bus_req)
    );

endmodule

// ==== sim/cpu_checker.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module cpu_checker #(
    parameter int PROG_WORDS = 401
) (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::bus_req_t bus_req,
    input  logic               bus_wait,
    output logic               done,
    output int                 error_count,
    output int                 instr_count
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam logic [31:0] LAST_PC = `CORE_RESET_VECTOR + 32'(4 * (PROG_WORDS - 1));

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];
    logic [`CORE_XLEN-1:0] mem [256];   // Own copy of the data region
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] ins;         // Load or store waiting on its transfer
    logic                  mem_phase;
    logic                  fetch_seen;  // Fetch completed on the last edge
    logic                  hold_prev;
    logic                  first_req;
    bus_req_t              req_prev;

    task automatic flag_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        error_count++;
        $display("[ERROR] %s expected %h actual %h at %0t ns", name, exp, act, $time);
    endtask

    task automatic flag_event(input string what);
        error_count++;
        $display("%s at %0t ns", what, $time);
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0)
            regs[rd] = value;
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub_sra,
                                              input logic [31:0] a, input logic [31:0] b);
        case (alu_op_e'(f3))
            ALU_ADD:  return sub_sra ? a - b : a + b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SR:   return sub_sra ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `CORE_RESET_VECTOR) >> 2;
        if (idx < PROG_WORDS)
            return tb_cpu.prog[idx];
        return 32'h00000013;  // NOP outside the program
    endfunction

    ////////////////////////////////////////////////////////////
    // Instruction-level model
    ////////////////////////////////////////////////////////////
    task automatic execute(input logic [31:0] w);
        logic [31:0] a, b, imm_i, next_pc;
        a       = regs[w[19:15]];
        b       = regs[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        next_pc = pc + 32'd4;
        case (w[6:0])
            OPC_LUI:   set_reg(w[11:7], {w[31:12], 12'b0});
            OPC_AUIPC: set_reg(w[11:7], pc + {w[31:12], 12'b0});
            OPC_JAL: begin
                set_reg(w[11:7], pc + 32'd4);
                next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                set_reg(w[11:7], pc + 32'd4);
                next_pc = a + imm_i;  // rs1 read before the link write
            end
            OPC_BRANCH:
                if (branch_model(w[14:12], a, b))
                    next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_OP_IMM: set_reg(w[11:7], alu_model(w[14:12], w[30] && w[14], a, imm_i));
            OPC_OP:     set_reg(w[11:7], alu_model(w[14:12], w[30], a, b));
            OPC_LOAD, OPC_STORE: mem_phase = 1'b1;
            default: ;  // FENCE, SYSTEM and unknown opcodes
        endcase
        ins = w;
        if (!mem_phase)
            pc = {next_pc[31:2], 2'b00};
    endtask

    task automatic finish_access();
        logic [31:0] addr, b, lane, data;
        logic [3:0]  sel;
        int          k;
        b = regs[ins[24:20]];
        if (ins[6:0] == OPC_STORE) begin
            addr = regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            case (ins[13:12])
                2'b00: begin
                    data = {4{b[7:0]}};
                    sel  = 4'b0001 << addr[1:0];
                end
                2'b01: begin
                    data = {2{b[15:0]}};
                    sel  = addr[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    data = b;
                    sel  = 4'b1111;
                end
            endcase
            if (!bus_req.wren)
                flag_event("Read seen where a store was expected");
            if (bus_req.addr != addr)
                flag_value("store_addr", addr, bus_req.addr);
            if (bus_req.bytesel != sel)
                flag_value("store_bytesel", 32'(sel), 32'(bus_req.bytesel));
            if (bus_req.wrdata != data)
                flag_value("store_data", data, bus_req.wrdata);
            for (k = 0; k < 4; k++)
                if (sel[k])
                    mem[addr[9:2]][8*k +: 8] = data[8*k +: 8];
        end else begin
            addr = regs[ins[19:15]] + {{20{ins[31]}}, ins[31:20]};
            if (bus_req.wren || bus_req.addr != addr)
                flag_event("Load address or direction does not match the model");
            lane = mem[addr[9:2]] >> {addr[1:0], 3'b000};
            case (ins[14:12])
                SZ_B:    data = {{24{lane[7]}}, lane[7:0]};
                SZ_H:    data = {{16{lane[15]}}, lane[15:0]};
                SZ_BU:   data = {24'b0, lane[7:0]};
                SZ_HU:   data = {16'b0, lane[15:0]};
                default: data = lane;
            endcase
            set_reg(ins[11:7], data);
        end
        mem_phase = 1'b0;
        pc        = pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (hold_prev && bus_req != req_prev)
                flag_event("Bus request changed while wait was high");
            if (bus_req.strobe == fetch_seen)
                flag_event("Strobe was not low for exactly the cycle after a fetch");
            if (first_req) begin
                first_req = 1'b0;
                if (bus_req.addr != `CORE_RESET_VECTOR)
                    flag_value("reset_vector", `CORE_RESET_VECTOR, bus_req.addr);
                if (!bus_req.strobe || bus_req.wren || bus_req.bytesel != 4'b1111)
                    flag_event("First request after reset is not a word read");
            end
            fetch_seen = 1'b0;
            if (bus_req.strobe && !bus_wait) begin
                if (mem_phase) begin
                    finish_access();
                end else begin
                    fetch_seen = 1'b1;
                    instr_count++;
                    if (bus_req.addr != pc)
                        flag_value("fetch_addr", pc, bus_req.addr);
                    if (bus_req.wren)
                        flag_event("Write enable high during a fetch");
                    if (pc == LAST_PC)
                        done = 1'b1;
                    execute(program_word(pc));
                end
            end
            hold_prev = bus_req.strobe && bus_wait;
            req_prev  = bus_req;
        end
    end

    initial begin
        int k;
        error_count = 0;
        instr_count = 0;
        done        = 1'b0;
        pc          = `CORE_RESET_VECTOR;
        mem_phase   = 1'b0;
        fetch_seen  = 1'b0;
        hold_prev   = 1'b0;
        first_req   = 1'b1;
        for (k = 0; k < `CORE_NUM_REGS; k++)
            regs[k] = '0;
        @(negedge reset);
        for (k = 0; k < 256; k++)
            mem[k] = tb_cpu.dmem[k];  // Preloaded data as the core first sees it
    end

endmodule

// ==== sim/tb_cpu.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module tb_cpu;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int PROG_WORDS     = NUM_INSTR + 1;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 3 * 4 + RESET_CYCLES;

    logic                  clk;
    logic                  reset;
    logic                  bus_wait;
    logic [`CORE_XLEN-1:0] bus_rddata;
    bus_req_t              bus_req;
    logic                  done;
    int                    error_count;
    int                    instr_count;
    logic [31:0]           rng_state;
    logic [31:0]           prog [PROG_WORDS];  // Program region at the reset vector
    logic [31:0]           dmem [256];         // 1 KB data region at address 0

    cpu_top DUT (
        .clk(clk), .reset(reset), .bus_req(bus_req), .bus_wait(bus_wait),
        .bus_rddata(bus_rddata)
    );

    cpu_checker #(.PROG_WORDS(PROG_WORDS)) u_checker (
        .clk(clk), .reset(reset), .bus_req(bus_req), .bus_wait(bus_wait),
        .done(done), .error_count(error_count), .instr_count(instr_count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [11:0] align_offset(input logic [11:0] off, input logic [2:0] f3);
        if (f3[1:0] == 2'b01)
            return {off[11:1], 1'b0};
        if (f3[1:0] == 2'b10)
            return {off[11:2], 2'b00};
        return off;
    endfunction

    ////////////////////////////////////////////////////////////
    // Random program generation
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] random_instr(input int idx);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [20:0] jump;
        int          span;
        r    = next_rand();
        r2   = next_rand();
        f3   = r[14:12];
        off  = {2'b00, r2[9:0]};
        span = 1 + int'(r2[12:10]);
        if (span > NUM_INSTR - idx)
            span = NUM_INSTR - idx;  // Never past the closing JAL
        jump = 21'(span * 4);
        case (r[2:0])
            3'd0, 3'd1: return {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, r[24:7], OPC_OP};
            3'd2, 3'd3: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    r[31:25] = {1'b0, r[30] && f3[2], 5'b0};  // SLLI, SRLI, SRAI
                return {r[31:7], OPC_OP_IMM};
            end
            3'd4: return (r[6:5] == 2'b00) ? 32'h0FF0000F :
                         {r[31:12], r[11:7], r[3] ? OPC_LUI : OPC_AUIPC};
            3'd5: begin
                if (f3 == 3'd3 || f3[2:1] == 2'b11)
                    f3 = f3 - 3'd2;  // Only LB, LH, LW, LBU, LHU
                return {align_offset(off, f3), 5'd0, f3, r[11:7], OPC_LOAD};
            end
            3'd6: begin
                f3  = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
                off = align_offset(off, f3);
                return {off[11:5], r[24:20], 5'd0, f3, off[4:0], OPC_STORE};
            end
            default: begin
                if (r[25])
                    return {jump[20], jump[10:1], jump[11], jump[19:12], r[11:7], OPC_JAL};
                if (f3[2:1] == 2'b01)
                    f3 = f3 + 3'd2;  // No branch funct3 of 2 or 3
                return {jump[12], jump[10:5], r[24:15], f3, jump[4:1], jump[11], OPC_BRANCH};
            end
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r;
        int          i;
        for (i = 0; i < 256; i++)
            dmem[i] = next_rand();
        // Known values in x1..x31 before random code reads them
        for (i = 1; i < 32; i++) begin
            r = next_rand();
            if (i % 2 == 1)
                prog[i-1] = {r[31:12], 5'(i), OPC_LUI};
            else
                prog[i-1] = {r[31:20], 5'd0, 3'd0, 5'(i), OPC_OP_IMM};
        end
        prog[31] = {20'd0, 5'd5, OPC_AUIPC};              // x5 = own address
        prog[32] = {12'd12, 5'd5, 3'd0, 5'd6, OPC_JALR};  // Lands on slot 34
        prog[33] = 32'h0000006F;                          // Spins if JALR misses
        prog[34] = 32'h0000007F;                          // Unknown opcode
        for (i = 35; i < NUM_INSTR; i++)
            prog[i] = random_instr(i);
        prog[NUM_INSTR] = 32'h0000006F;                   // JAL x0, 0
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `CORE_RESET_VECTOR) >> 2;
        if (idx < PROG_WORDS)
            return prog[idx];
        if (addr < 32'd1024)
            return dmem[addr[9:2]];
        return '0;
    endfunction

    // Memory model, read data valid in the completing cycle
    always @(posedge clk) begin
        if (!reset && bus_req.strobe && !bus_wait && bus_req.wren && bus_req.addr < 32'd1024) begin
            for (int k = 0; k < 4; k++)
                if (bus_req.bytesel[k])
                    dmem[bus_req.addr[9:2]][8*k +: 8] = bus_req.wrdata[8*k +: 8];
        end
        #1;
        bus_wait   = (next_rand() % 4 == 0);
        bus_rddata = read_word(bus_req.addr);
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        bus_wait   = 1'b0;
        bus_rddata = '0;
        rng_state  = 32'h274;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        wait (done);
        repeat (4) @(posedge clk);
        $display("Instructions executed: %0d, errors: %0d", instr_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * 8);
        $display("Timeout: final instruction not reached in %0d cycles", TIMEOUT_CYCLES);
        $display("Instructions executed: %0d, errors: %0d", instr_count, error_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== riscv_core.f ====
+incdir+src
src/rv_isa_pkg.sv
src/core_pkg.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/load_store_unit.sv
src/cpu_control.sv
src/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv
